// ==== Makefile ====
SRCS := $(wildcard design/*.sv design/*.svh verification/*.sv)

obj_dir/Vloader_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module loader_tb -f filelist.f

run: obj_dir/Vloader_tb
	./obj_dir/Vloader_tb +verilator+error+limit+100 | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== design/crt_header_parser.sv ====
// Cartridge file parser.
// Captures the file header fields and each chip packet header, and marks
// the packet start and data bytes for the address unit.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module crt_header_parser (
	input  wire                          clk_sys,
	input  wire                          reset_n,
	input  wire loader_pkg::load_kind_e  byte_kind_i,
	input  wire                          byte_wr_i,
	input  wire [`LD_ADDR_W-1:0]         dl_addr_i,
	input  wire [7:0]                    dl_data_i,
	output logic                         crt_start_o,
	output logic                         crt_align_o,
	output logic                         crt_store_o,
	output logic [15:0]                  cart_id_o,
	output logic [7:0]                   cart_exrom_o,
	output logic [7:0]                   cart_game_o,
	output logic [7:0]                   bank_type_o,
	output logic [15:0]                  bank_num_o,
	output logic [15:0]                  bank_laddr_o,
	output logic [15:0]                  bank_size_o,
	output logic                         bank_hdr_wr_o
);
	import loader_pkg::*;

	crt_state_e  crt_state;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        cart_wr;
	logic        in_chips;

	assign cart_wr  = byte_wr_i && (byte_kind_i == LOAD_CRT);
	assign in_chips = (dl_addr_i >= `LD_CRT_CHIP_OFS);

	assign crt_start_o = cart_wr && (dl_addr_i == '0);
	// A packet starts after the file header or when the last one ran out
	assign crt_align_o = cart_wr && in_chips &&
		((crt_state == CRT_FILE_HDR) || (crt_state == CRT_DATA && blk_len == '0));
	assign crt_store_o = cart_wr && in_chips && (crt_state == CRT_DATA) && (blk_len != '0);

	// ====================
	// Parse FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			crt_state     <= CRT_FILE_HDR;
			hdr_cnt       <= '0;
			blk_len       <= '0;
			bank_hdr_wr_o <= 1'b0;
		end else begin
			bank_hdr_wr_o <= 1'b0;
			if (crt_start_o) begin
				crt_state <= CRT_FILE_HDR;
				hdr_cnt   <= '0;
				blk_len   <= '0;
			end else if (crt_align_o) begin
				// Byte 0 of the packet header is taken here
				crt_state <= CRT_CHIP_HDR;
				hdr_cnt   <= 4'd1;
			end else if (cart_wr && crt_state == CRT_CHIP_HDR) begin
				hdr_cnt <= hdr_cnt + 4'd1;
				case (hdr_cnt)
					4'd4: blk_len[31:24] <= dl_data_i;
					4'd5: blk_len[23:16] <= dl_data_i;
					4'd6: blk_len[15:8]  <= dl_data_i;
					4'd7: blk_len[7:0]   <= dl_data_i;
					// Packet length includes its own header
					4'd8: blk_len <= blk_len - `LD_CHIP_HDR_LEN;
					4'd15: begin
						crt_state     <= CRT_DATA;
						bank_hdr_wr_o <= 1'b1;
					end
					default: ;
				endcase
			end else if (crt_store_o) begin
				blk_len <= blk_len - 32'd1;
			end
		end
	end

	// Header fields
	always_ff @(posedge clk_sys) begin
		if (cart_wr && crt_state == CRT_FILE_HDR) begin
			if (dl_addr_i == `LD_CRT_ID_OFS)
				cart_id_o[15:8] <= dl_data_i;
			if (dl_addr_i == `LD_CRT_ID_OFS + 8'd1)
				cart_id_o[7:0] <= dl_data_i;
			if (dl_addr_i == `LD_CRT_ID_OFS + 8'd2)
				cart_exrom_o <= dl_data_i;
			if (dl_addr_i == `LD_CRT_ID_OFS + 8'd3)
				cart_game_o <= dl_data_i;
		end
		if (cart_wr && crt_state == CRT_CHIP_HDR) begin
			case (hdr_cnt)
				4'd9:  bank_type_o        <= dl_data_i;
				4'd10: bank_num_o[15:8]   <= dl_data_i;
				4'd11: bank_num_o[7:0]    <= dl_data_i;
				4'd12: bank_laddr_o[15:8] <= dl_data_i;
				4'd13: bank_laddr_o[7:0]  <= dl_data_i;
				4'd14: bank_size_o[15:8]  <= dl_data_i;
				4'd15: bank_size_o[7:0]   <= dl_data_i;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/download_decoder.sv ====
// Input side of the loader.
// Sorts each host byte by file index and keeps the cartridge-attached flag.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module download_decoder (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    dl_active_i,
	input  wire [7:0]              dl_index_i,
	input  wire                    dl_wr_i,
	output loader_pkg::load_kind_e byte_kind_o,
	output logic                   byte_wr_o,
	output logic                   cart_attached_o
);
	import loader_pkg::*;

	load_kind_e idx_kind;
	logic       active_d;

	// Index to file kind, independent of the active flag
	always_comb begin
		if (dl_index_i[7:6] == 2'b00 && dl_index_i[5:0] == `LD_IDX_PRG)
			idx_kind = LOAD_PRG;
		else if (dl_index_i == `LD_IDX_CRT_A || dl_index_i == `LD_IDX_CRT_B)
			idx_kind = LOAD_CRT;
		else if (dl_index_i == `LD_IDX_TAP)
			idx_kind = LOAD_TAP;
		else
			idx_kind = LOAD_NONE;
	end

	always_comb begin
		if (dl_active_i)
			byte_kind_o = idx_kind;
		else
			byte_kind_o = LOAD_NONE;
	end

	// Unknown kinds never reach the rest of the loader
	assign byte_wr_o = dl_wr_i && (byte_kind_o != LOAD_NONE);

	// Detached while a cartridge loads, attached once it is complete
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_d        <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			active_d <= dl_active_i;
			if (active_d != dl_active_i && idx_kind == LOAD_CRT)
				cart_attached_o <= active_d;
		end
	end

endmodule

`default_nettype wire

// ==== design/load_address_unit.sv ====
// Running load address for program, tape and cartridge files.
// Issues one store request per byte that goes to memory.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module load_address_unit (
	input  wire                          clk_sys,
	input  wire                          reset_n,
	input  wire loader_pkg::load_kind_e  byte_kind_i,
	input  wire                          byte_wr_i,
	input  wire [`LD_ADDR_W-1:0]         dl_addr_i,
	input  wire [7:0]                    dl_data_i,
	input  wire                          crt_start_i,
	input  wire                          crt_align_i,
	input  wire                          crt_store_i,
	output logic                         store_req_o,
	output logic [`LD_ADDR_W-1:0]        store_addr_o,
	output logic [7:0]                   store_data_o
);
	import loader_pkg::*;

	// Offset of the high load address byte in a program file
	localparam logic [`LD_ADDR_W-1:0] PRG_HI_OFS = 1;

	logic                  prg_wr;
	logic                  tap_wr;
	logic                  first_byte;
	logic [`LD_ADDR_W-1:0] load_addr;

	assign prg_wr     = byte_wr_i && (byte_kind_i == LOAD_PRG);
	assign tap_wr     = byte_wr_i && (byte_kind_i == LOAD_TAP);
	assign first_byte = (dl_addr_i == '0);

	// Program bytes 0 and 1 carry the address and are not stored
	assign store_req_o = (prg_wr && dl_addr_i[`LD_ADDR_W-1:1] != '0) || tap_wr || crt_store_i;

	// Tape byte 0 goes straight to the base
	assign store_addr_o = (tap_wr && first_byte) ? `LD_TAP_BASE : load_addr;
	assign store_data_o = dl_data_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr <= '0;
		end else if (store_req_o) begin
			load_addr <= store_addr_o + 1'b1;
		end else if (crt_start_i) begin
			load_addr <= `LD_CRT_BASE;
		end else if (crt_align_i && load_addr[`LD_ALIGN_BITS-1:0] != '0) begin
			// Round up to the next 8 KB boundary
			load_addr <= {load_addr[`LD_ADDR_W-1:`LD_ALIGN_BITS] + 1'b1,
				{`LD_ALIGN_BITS{1'b0}}};
		end else if (prg_wr && first_byte) begin
			load_addr <= {{(`LD_ADDR_W-8){1'b0}}, dl_data_i};
		end else if (prg_wr && dl_addr_i == PRG_HI_OFS) begin
			load_addr[15:8] <= dl_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/loader_defines.svh ====
// Shared constants of the download loader.
// Include in any file that needs file indices, base addresses or header offsets.
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// Memory address width
`define LD_ADDR_W 25

// File indices from the host
`define LD_IDX_PRG   6'd4
`define LD_IDX_CRT_A 8'd5
`define LD_IDX_CRT_B 8'hC0
`define LD_IDX_TAP   8'd6

// Base addresses in memory
`define LD_TAP_BASE 25'h200000
`define LD_CRT_BASE 25'h100000

// Cartridge file layout
`define LD_CRT_CHIP_OFS 8'h40
`define LD_CRT_ID_OFS   8'h16
`define LD_CHIP_HDR_LEN 16
`define LD_ALIGN_BITS   13

`endif

// ==== design/loader_pkg.sv ====
// Types shared by the loader blocks.
// Import where a file kind or a cartridge parse state is needed.
`default_nettype none

package loader_pkg;

	// ====================
	// File kind of one host byte
	// ====================
	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_TAP
	} load_kind_e;

	// ====================
	// Cartridge parse state
	// ====================
	// File header first, then chip packet header and data in turn
	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_CHIP_HDR,
		CRT_DATA
	} crt_state_e;

endpackage

`default_nettype wire

// ==== design/mem_write_port.sv ====
// Output side of the loader.
// Holds one store on the memory port until it is acknowledged, and holds
// the host off meanwhile.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module mem_write_port (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    store_req_i,
	input  wire [`LD_ADDR_W-1:0]   store_addr_i,
	input  wire [7:0]              store_data_i,
	input  wire                    mem_ack_i,
	output logic                   mem_wr_o,
	output logic [`LD_ADDR_W-1:0]  mem_addr_o,
	output logic [7:0]             mem_data_o,
	output logic                   dl_wait_o
);

	logic pending;

	// Pending flag, cleared the cycle after the acknowledge
	always_ff @(posedge clk_sys) begin
		if (!reset_n)
			pending <= 1'b0;
		else if (store_req_i)
			pending <= 1'b1;
		else if (mem_ack_i)
			pending <= 1'b0;
	end

	// Store payload
	always_ff @(posedge clk_sys) begin
		if (store_req_i) begin
			mem_addr_o <= store_addr_i;
			mem_data_o <= store_data_i;
		end
	end

	assign mem_wr_o  = pending;
	assign dl_wait_o = pending;

endmodule

`default_nettype wire

// ==== design/rom_loader_top.sv ====
// Download loader top level.
// Host byte stream in, memory stores out, plus the cartridge header fields.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module rom_loader_top (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    dl_active_i,
	input  wire [7:0]              dl_index_i,
	input  wire [`LD_ADDR_W-1:0]   dl_addr_i,
	input  wire [7:0]              dl_data_i,
	input  wire                    dl_wr_i,
	input  wire                    mem_ack_i,
	output logic                   dl_wait_o,
	output logic                   mem_wr_o,
	output logic [`LD_ADDR_W-1:0]  mem_addr_o,
	output logic [7:0]             mem_data_o,
	output logic                   cart_attached_o,
	output logic [15:0]            cart_id_o,
	output logic [7:0]             cart_exrom_o,
	output logic [7:0]             cart_game_o,
	output logic [7:0]             bank_type_o,
	output logic [15:0]            bank_num_o,
	output logic [15:0]            bank_laddr_o,
	output logic [15:0]            bank_size_o,
	output logic                   bank_hdr_wr_o
);
	import loader_pkg::*;

	load_kind_e            byte_kind;
	logic                  byte_wr;
	logic                  crt_start;
	logic                  crt_align;
	logic                  crt_store;
	logic                  store_req;
	logic [`LD_ADDR_W-1:0] store_addr;
	logic [7:0]            store_data;

	download_decoder u_decoder (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.byte_kind_o     (byte_kind),
		.byte_wr_o       (byte_wr),
		.cart_attached_o (cart_attached_o)
	);

	crt_header_parser u_parser (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.byte_kind_i   (byte_kind),
		.byte_wr_i     (byte_wr),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.crt_start_o   (crt_start),
		.crt_align_o   (crt_align),
		.crt_store_o   (crt_store),
		.cart_id_o     (cart_id_o),
		.cart_exrom_o  (cart_exrom_o),
		.cart_game_o   (cart_game_o),
		.bank_type_o   (bank_type_o),
		.bank_num_o    (bank_num_o),
		.bank_laddr_o  (bank_laddr_o),
		.bank_size_o   (bank_size_o),
		.bank_hdr_wr_o (bank_hdr_wr_o)
	);

	load_address_unit u_addr (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.byte_kind_i  (byte_kind),
		.byte_wr_i    (byte_wr),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.crt_start_i  (crt_start),
		.crt_align_i  (crt_align),
		.crt_store_i  (crt_store),
		.store_req_o  (store_req),
		.store_addr_o (store_addr),
		.store_data_o (store_data)
	);

	mem_write_port u_port (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.store_req_i  (store_req),
		.store_addr_i (store_addr),
		.store_data_i (store_data),
		.mem_ack_i    (mem_ack_i),
		.mem_wr_o     (mem_wr_o),
		.mem_addr_o   (mem_addr_o),
		.mem_data_o   (mem_data_o),
		.dl_wait_o    (dl_wait_o)
	);

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/loader_pkg.sv
design/download_decoder.sv
design/crt_header_parser.sv
design/load_address_unit.sv
design/mem_write_port.sv
design/rom_loader_top.sv
verification/loader_asserts.sv
verification/loader_tb.sv

// ==== verification/loader_asserts.sv ====
// Handshake checks on the loader top level, attached by bind.
// Memory store hold, host wait and bank header strobe width.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module loader_asserts (
	input wire                  clk_sys,
	input wire                  reset_n,
	input wire                  mem_wr_i,
	input wire                  mem_ack_i,
	input wire [`LD_ADDR_W-1:0] mem_addr_i,
	input wire [7:0]            mem_data_i,
	input wire                  dl_wait_i,
	input wire                  bank_hdr_wr_i
);

	// Failures seen so far, read by the testbench at the end
	int unsigned fail_cnt = 0;

	// A store stays on the port until its acknowledge
	store_held: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_wr_i && !mem_ack_i |=> mem_wr_i && $stable(mem_addr_i) && $stable(mem_data_i))
	else begin
		$error("memory store changed before its acknowledge");
		fail_cnt++;
	end

	// Host is held exactly while a store is pending
	wait_match: assert property (@(posedge clk_sys) disable iff (!reset_n)
		dl_wait_i == mem_wr_i)
	else begin
		$error("dl_wait_o differs from mem_wr_o");
		fail_cnt++;
	end

	bank_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_hdr_wr_i |=> !bank_hdr_wr_i)
	else begin
		$error("bank_hdr_wr_o longer than one cycle");
		fail_cnt++;
	end

endmodule

bind rom_loader_top loader_asserts u_asserts (
	.clk_sys       (clk_sys),
	.reset_n       (reset_n),
	.mem_wr_i      (mem_wr_o),
	.mem_ack_i     (mem_ack_i),
	.mem_addr_i    (mem_addr_o),
	.mem_data_i    (mem_data_o),
	.dl_wait_i     (dl_wait_o),
	.bank_hdr_wr_i (bank_hdr_wr_o)
);

`default_nettype wire

// ==== verification/loader_tb.sv ====
// Testbench for the download loader.
// Sends program, tape and cartridge files through the host port, answers the
// memory port after random delays and checks each store against a queue model.
`timescale 1ns/100ps
`default_nettype none

`include "loader_defines.svh"

module loader_tb;

	localparam logic [15:0] CART_ID    = 16'h0020;
	localparam logic [7:0]  CART_EXROM = 8'h01;
	localparam logic [7:0]  CART_GAME  = 8'h00;
	localparam logic [7:0]  CHIP_TYPE  = 8'h02;
	localparam int          ALIGN_MASK = (1 << `LD_ALIGN_BITS) - 1;

	logic                  clk_sys = 1'b0;
	logic                  reset_n;
	logic                  dl_active_i;
	logic [7:0]            dl_index_i;
	logic [`LD_ADDR_W-1:0] dl_addr_i;
	logic [7:0]            dl_data_i;
	logic                  dl_wr_i;
	logic                  mem_ack_i;
	logic                  dl_wait_o;
	logic                  mem_wr_o;
	logic [`LD_ADDR_W-1:0] mem_addr_o;
	logic [7:0]            mem_data_o;
	logic                  cart_attached_o;
	logic [15:0]           cart_id_o;
	logic [7:0]            cart_exrom_o;
	logic [7:0]            cart_game_o;
	logic [7:0]            bank_type_o;
	logic [15:0]           bank_num_o;
	logic [15:0]           bank_laddr_o;
	logic [15:0]           bank_size_o;
	logic                  bank_hdr_wr_o;

	integer                seed = 32'hb13a;
	int                    err_cnt = 0;
	int                    last_err = 0;
	int                    check_cnt = 0;
	int                    test_cnt = 0;
	int                    store_cnt = 0;
	int                    hdr_pulses = 0;
	int                    ack_wait = 0;
	int                    ack_mask = 1;
	logic [`LD_ADDR_W-1:0] exp_addr_q[$];
	logic [7:0]            exp_data_q[$];
	logic [7:0]            seen_type;
	logic [15:0]           seen_num;
	logic [15:0]           seen_laddr;
	logic [15:0]           seen_size;

	rom_loader_top DUT (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.mem_ack_i       (mem_ack_i),
		.dl_wait_o       (dl_wait_o),
		.mem_wr_o        (mem_wr_o),
		.mem_addr_o      (mem_addr_o),
		.mem_data_o      (mem_data_o),
		.cart_attached_o (cart_attached_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_hdr_wr_o   (bank_hdr_wr_o)
	);

	always #2 clk_sys = ~clk_sys;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic take_store();
		store_cnt++;
		if (exp_addr_q.size() == 0) begin
			$display("Unexpected store at t=%0t to address %h", $time, mem_addr_o);
			err_cnt++;
		end else begin
			check_val("mem_addr_o", mem_addr_o, exp_addr_q.pop_front());
			check_val("mem_data_o", mem_data_o, exp_data_q.pop_front());
		end
	endtask

	// ====================
	// Memory responder
	// ====================
	always @(negedge clk_sys) begin
		if (mem_ack_i) begin
			mem_ack_i = 1'b0;
		end else if (mem_wr_o) begin
			if (ack_wait == 0) begin
				take_store();
				mem_ack_i = 1'b1;
				ack_wait = $random(seed) & ack_mask;
			end else begin
				ack_wait = ack_wait - 1;
			end
		end
	end

	// Bank fields as seen on the header strobe
	always @(negedge clk_sys) begin
		if (bank_hdr_wr_o) begin
			hdr_pulses++;
			seen_type  = bank_type_o;
			seen_num   = bank_num_o;
			seen_laddr = bank_laddr_o;
			seen_size  = bank_size_o;
		end
	end

	// ====================
	// Host side
	// ====================
	task automatic send_byte(input logic [`LD_ADDR_W-1:0] ofs, input logic [7:0] data,
			input logic stores, input logic [`LD_ADDR_W-1:0] addr);
		int n;
		if (stores) begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back(data);
		end
		dl_addr_i = ofs;
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		// Store shows one cycle after the strobe, header bytes leave the host free
		check_val("mem_wr_o", mem_wr_o, stores);
		check_val("dl_wait_o", dl_wait_o, stores);
		@(negedge clk_sys);
		n = 0;
		while (dl_wait_o && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (dl_wait_o) begin
			$display("Timeout at t=%0t, dl_wait_o stayed high for 64 cycles", $time);
			err_cnt++;
		end
	endtask

	task automatic open_download(input logic [7:0] index);
		dl_index_i  = index;
		dl_active_i = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic close_download();
		dl_active_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic program_file(input int len);
		logic [15:0] load;
		int          k;
		load = $random(seed);
		open_download({2'b00, `LD_IDX_PRG});
		send_byte(0, load[7:0], 1'b0, '0);
		send_byte(1, load[15:8], 1'b0, '0);
		// Byte 2 lands on the load address itself
		for (k = 2; k < len; k++)
			send_byte(k, $random(seed), 1'b1, load + k - 2);
		close_download();
	endtask

	task automatic tape_file(input int len);
		int k;
		open_download(`LD_IDX_TAP);
		for (k = 0; k < len; k++)
			send_byte(k, $random(seed), 1'b1, `LD_TAP_BASE + k);
		close_download();
	endtask

	function automatic logic [7:0] crt_file_byte(input int ofs);
		case (ofs)
			`LD_CRT_ID_OFS:     return CART_ID[15:8];
			`LD_CRT_ID_OFS + 1: return CART_ID[7:0];
			`LD_CRT_ID_OFS + 2: return CART_EXROM;
			`LD_CRT_ID_OFS + 3: return CART_GAME;
			default:            return ofs[7:0] ^ 8'hA5;
		endcase
	endfunction

	task automatic chip_packet(inout logic [`LD_ADDR_W-1:0] ofs,
			inout logic [`LD_ADDR_W-1:0] addr, input int len,
			input logic [15:0] bank, input logic [15:0] laddr);
		logic [7:0]  hdr [16];
		logic [31:0] pkt_len;
		int          pulses;
		int          k;
		pkt_len = `LD_CHIP_HDR_LEN + len;
		// CHIP tag, big-endian length, type, bank, load address, size
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, pkt_len[31:24], pkt_len[23:16],
			pkt_len[15:8], pkt_len[7:0], 8'h00, CHIP_TYPE, bank[15:8], bank[7:0],
			laddr[15:8], laddr[7:0], len[15:8], len[7:0]};
		pulses = hdr_pulses;
		for (k = 0; k < `LD_CHIP_HDR_LEN; k++) begin
			send_byte(ofs, hdr[k], 1'b0, '0);
			ofs++;
		end
		check_val("bank_hdr_wr_o pulses", hdr_pulses - pulses, 1);
		check_val("bank_type_o", seen_type, CHIP_TYPE);
		check_val("bank_num_o", seen_num, bank);
		check_val("bank_laddr_o", seen_laddr, laddr);
		check_val("bank_size_o", seen_size, len);
		addr = (addr + ALIGN_MASK) & ~ALIGN_MASK;
		for (k = 0; k < len; k++) begin
			send_byte(ofs, $random(seed), 1'b1, addr);
			ofs++;
			addr++;
		end
	endtask

	task automatic cartridge_file(input logic [7:0] index);
		logic [`LD_ADDR_W-1:0] ofs;
		logic [`LD_ADDR_W-1:0] addr;
		int                    k;
		open_download(index);
		check_val("cart_attached_o", cart_attached_o, 1'b0);
		for (k = 0; k < `LD_CRT_CHIP_OFS; k++)
			send_byte(k, crt_file_byte(k), 1'b0, '0);
		check_val("cart_id_o", cart_id_o, CART_ID);
		check_val("cart_exrom_o", cart_exrom_o, CART_EXROM);
		check_val("cart_game_o", cart_game_o, CART_GAME);
		ofs  = `LD_CRT_CHIP_OFS;
		addr = `LD_CRT_BASE;
		// Odd first packet pushes the second one to the next 8 KB boundary
		chip_packet(ofs, addr, 37, 16'h0000, 16'h8000);
		chip_packet(ofs, addr, 12, 16'h0001, 16'hA000);
		close_download();
		check_val("cart_attached_o", cart_attached_o, 1'b1);
	endtask

	task automatic end_test(input string name);
		check_val("queued stores", exp_addr_q.size(), 0);
		test_cnt++;
		$display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - last_err);
		last_err = err_cnt;
	endtask

	initial begin
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		dl_wr_i     = 1'b0;
		mem_ack_i   = 1'b0;
		repeat (8) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);

		check_val("mem_wr_o", mem_wr_o, 1'b0);
		check_val("dl_wait_o", dl_wait_o, 1'b0);
		check_val("bank_hdr_wr_o", bank_hdr_wr_o, 1'b0);
		check_val("cart_attached_o", cart_attached_o, 1'b0);
		end_test("reset state");
		program_file(24);
		end_test("program file");
		tape_file(20);
		end_test("tape file");
		cartridge_file(`LD_IDX_CRT_A);
		end_test("cartridge file");
		// Starts attached, so the falling flag is visible here
		cartridge_file(`LD_IDX_CRT_B);
		end_test("cartridge attach flag");
		ack_mask = 7;
		program_file(40);
		tape_file(40);
		end_test("back-pressure");

		$display("Summary: %0d tests, %0d checks, %0d stores, %0d errors, %0d assertion failures",
			test_cnt, check_cnt, store_cnt, err_cnt, DUT.u_asserts.fail_cnt);
		if (err_cnt == 0 && DUT.u_asserts.fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
